//--- run_sim.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    --top-module mem_subsystem_tb \
    -Mdir "$BUILD_DIR" \
    -f vlog.f

# Simulation status is taken from the log, not the exit code
"./$BUILD_DIR/Vmem_subsystem_tb" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "All checks passed" "$LOG"; then
    echo "simulation PASSED"
    exit 0
else
    echo "simulation FAILED, see $LOG"
    exit 1
fi

//--- verif/mem_patterns.txt
// Columns: op address data mask expect, hex. Ops: 1 fabric write, 2 fabric read, 3 fetch,
// 4 load, 5 store, 6 miss (mask 1 write), 7 write with core read, 8 burst read, 9 random write
// Preload and fetch back
1 01000000 00000013 0 0
1 01000004 00c58533 0 0
1 01000008 fe010113 0 0
1 0100000c 00112e23 0 0
3 00000000 0 f 00000013
3 00000004 0 f 00c58533
3 0000000c 0 f 00112e23
2 01000008 0 f fe010113
// Partial stores into the data memory
1 02000010 11223344 0 0
5 00000010 aabbccdd 1 0
4 00000010 0 f 112233dd
5 00000010 55667788 c 0
4 00000010 0 f 556633dd
2 02000010 0 f 556633dd
5 00000014 cafef00d f 0
5 00000014 00000099 2 0
2 02000014 0 f cafe000d
// Unmapped regions, word 4 untouched in both memories
1 01000010 0badf00d 0 0
6 03000010 deadbeef 1 0
6 ff000010 0 0 0
3 00000010 0 f 0badf00d
2 02000010 0 f 556633dd
// Same-word write and read, old then new
7 01000000 87654321 f 00000013
3 00000000 0 f 87654321
7 02000014 12345678 f cafe000d
4 00000014 0 f 12345678
// Random background, then alternating back-to-back reads
9 01000020 0 0 0
9 02000020 0 0 0
8 01000000 0 f 87654321
8 02000010 0 f 556633dd
8 01000020 0 0 0
8 02000020 0 0 0
8 01000004 0 f 00c58533
8 02000014 0 f 12345678
4 00000020 0 0 0

//--- verif/mem_subsystem_props.sv
`timescale 1ns/1ps

module mem_subsystem_props (
    input  logic                 qclk,
    input  logic                 rst_n,
    input  logic                 f2c_req_valid,
    input  lotr_pkg::t_opcode    f2c_req_opcode,
    input  logic [31:0]          f2c_req_address,
    input  logic                 f2c_rsp_valid,
    input  logic                 rsp_imem_valid,
    input  logic                 rsp_dmem_valid
);

    logic [lotr_pkg::REGION_W-1:0] region;
    logic                          rd_hit;

    // Fabric read into either memory
    assign region = f2c_req_address[lotr_pkg::MSB_REGION:lotr_pkg::LSB_REGION];
    assign rd_hit = f2c_req_valid && (f2c_req_opcode == lotr_pkg::RD)
                    && ((region == lotr_pkg::I_MEM_REGION) || (region == lotr_pkg::D_MEM_REGION));

    // Low in every reset cycle and the first one after release
    rsp_low_in_reset: assert property (@(posedge qclk) !rst_n |=> !f2c_rsp_valid)
        else $error("response valid seen after a reset cycle");

    // Each response cycle needs a read hit one cycle earlier
    rsp_after_read: assert property (@(posedge qclk) disable iff (!rst_n)
        f2c_rsp_valid |-> $past(rd_hit))
        else $error("response valid without a read hit the cycle before");

    // Disjoint regions, one responder at most
    one_responder: assert property (@(posedge qclk) disable iff (!rst_n)
        !(rsp_imem_valid && rsp_dmem_valid))
        else $error("both memories answered in the same cycle");

endmodule

bind mem_subsystem mem_subsystem_props props (
    .qclk            (qclk),
    .rst_n           (rst_n),
    .f2c_req_valid   (f2c_req_valid),
    .f2c_req_opcode  (f2c_req_opcode),
    .f2c_req_address (f2c_req_address),
    .f2c_rsp_valid   (f2c_rsp_valid),
    .rsp_imem_valid  (rsp_imem_valid),
    .rsp_dmem_valid  (rsp_dmem_valid)
);

//--- verif/mem_subsystem_tb.sv
`timescale 1ns/1ps

module mem_subsystem_tb;

    localparam int          I_MEM_AW       = 9;
    localparam int          D_MEM_AW       = 9;
    localparam int          RESET_CYCLES   = 4;
    localparam int          MAX_PATTERNS   = 64;
    localparam int          TIMEOUT_MARGIN = 50;
    localparam logic [31:0] LFSR_SEED      = 32'h1a44;

    logic              qclk;
    logic              rst_n;
    logic [31:0]       pc;
    logic              fetch_en;
    logic [31:0]       instr;
    logic [31:0]       d_addr;
    logic              d_rd_en;
    logic              d_wr_en;
    logic [3:0]        d_byte_en;
    logic [31:0]       d_wr_data;
    logic [31:0]       d_rd_data;
    logic              f2c_req_valid;
    lotr_pkg::t_opcode f2c_req_opcode;
    logic [31:0]       f2c_req_address;
    logic [31:0]       f2c_req_data;
    logic              f2c_rsp_valid;
    logic [31:0]       f2c_rsp_data;

    // Reference model of both memories, pattern table, LFSR state
    logic [31:0] imem_model [0:(2**I_MEM_AW)-1];
    logic [31:0] dmem_model [0:(2**D_MEM_AW)-1];
    logic [31:0] patterns [0:5*MAX_PATTERNS-1];
    logic [31:0] lfsr_state;
    int          n_patterns;
    int          cycle_limit;
    int          cycle_count;
    int          checks;
    int          errors;

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(RESET_CYCLES)) clk_gen (
        .qclk  (qclk),
        .rst_n (rst_n)
    );

    mem_subsystem #(.I_MEM_AW(I_MEM_AW), .D_MEM_AW(D_MEM_AW)) DUT (.*);

    // ==========================================================
    // Model and helpers
    // ==========================================================

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic random_word(output logic [31:0] word);
        for (int b = 0; b < 32; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            word[b]    = lfsr_state[0];
        end
    endtask

    function automatic logic is_imem(input logic [31:0] addr);
        return addr[lotr_pkg::MSB_REGION:lotr_pkg::LSB_REGION] == lotr_pkg::I_MEM_REGION;
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        if (is_imem(addr)) begin
            return imem_model[addr[I_MEM_AW+1:2]];
        end
        return dmem_model[addr[D_MEM_AW+1:2]];
    endfunction

    // Byte-lane update of the model where the region picks the memory
    task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] mask);
        for (int b = 0; b < 4; b++) begin
            if (mask[b] && is_imem(addr)) begin
                imem_model[addr[I_MEM_AW+1:2]][8*b +: 8] = data[8*b +: 8];
            end else if (mask[b]) begin
                dmem_model[addr[D_MEM_AW+1:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    function automatic logic [31:0] pattern_field(input int idx, input int col);
        return patterns[5*idx + col];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Model always checked and the file value too when the mask column is set
    task automatic check_read(input string name, input logic [31:0] got,
                              input logic [31:0] addr, input logic [3:0] mask,
                              input logic [31:0] file_exp);
        check_value(name, got, model_word(addr));
        if (mask != 4'h0) begin
            check_value(name, got, file_exp);
        end
    endtask

    // ==========================================================
    // Drivers
    // ==========================================================

    task automatic drive_idle();
        pc              <= 32'h0;
        fetch_en        <= 1'b0;
        d_addr          <= 32'h0;
        d_rd_en         <= 1'b0;
        d_wr_en         <= 1'b0;
        d_byte_en       <= 4'h0;
        d_wr_data       <= 32'h0;
        f2c_req_valid   <= 1'b0;
        f2c_req_opcode  <= lotr_pkg::RD;
        f2c_req_address <= 32'h0;
        f2c_req_data    <= 32'h0;
    endtask

    task automatic drive_fabric(input lotr_pkg::t_opcode op, input logic [31:0] addr,
                                input logic [31:0] data);
        f2c_req_valid   <= 1'b1;
        f2c_req_opcode  <= op;
        f2c_req_address <= addr;
        f2c_req_data    <= data;
    endtask

    // One request cycle that ends where the response is visible
    task automatic fabric_cycle(input lotr_pkg::t_opcode op, input logic [31:0] addr,
                                input logic [31:0] data);
        @(posedge qclk);
        drive_fabric(op, addr, data);
        @(posedge qclk);
        drive_idle();
        @(negedge qclk);
    endtask

    // Reads every cycle with each response checked one cycle later
    task automatic fabric_burst(input int first, input int count);
        int          p;
        logic [31:0] mask_col;
        for (int c = 0; c <= count; c++) begin
            @(posedge qclk);
            if (c < count) begin
                drive_fabric(lotr_pkg::RD, pattern_field(first + c, 1), 32'h0);
            end else begin
                drive_idle();
            end
            @(negedge qclk);
            if (c > 0) begin
                p        = first + c - 1;
                mask_col = pattern_field(p, 3);
                check_value("f2c_rsp_valid", {31'h0, f2c_rsp_valid}, 32'h1);
                check_read("f2c_rsp_data", f2c_rsp_data, pattern_field(p, 1),
                           mask_col[3:0], pattern_field(p, 4));
            end
        end
        @(negedge qclk);
        check_value("f2c_rsp_valid", {31'h0, f2c_rsp_valid}, 32'h0);
    endtask

    task automatic run_pattern(input int idx);
        logic [31:0]       op;
        logic [31:0]       addr;
        logic [31:0]       data;
        logic [31:0]       mask;
        logic [31:0]       exp;
        lotr_pkg::t_opcode miss_op;
        op   = pattern_field(idx, 0);
        addr = pattern_field(idx, 1);
        data = pattern_field(idx, 2);
        mask = pattern_field(idx, 3);
        exp  = pattern_field(idx, 4);
        case (op)
            // Fabric write or random fabric write
            32'h1, 32'h9: begin
                if (op == 32'h9) begin
                    random_word(data);
                end
                fabric_cycle(lotr_pkg::WR, addr, data);
                model_write(addr, data, 4'hf);
                check_value("f2c_rsp_valid", {31'h0, f2c_rsp_valid}, 32'h0);
            end
            // Fabric read with a pulse of exactly one cycle
            32'h2: begin
                fabric_cycle(lotr_pkg::RD, addr, 32'h0);
                check_value("f2c_rsp_valid", {31'h0, f2c_rsp_valid}, 32'h1);
                check_read("f2c_rsp_data", f2c_rsp_data, addr, mask[3:0], exp);
                @(negedge qclk);
                check_value("f2c_rsp_valid", {31'h0, f2c_rsp_valid}, 32'h0);
            end
            // Fetch and then instr holds with fetch_en low
            32'h3: begin
                @(posedge qclk);
                pc       <= addr;
                fetch_en <= 1'b1;
                @(posedge qclk);
                drive_idle();
                repeat (2) begin
                    @(negedge qclk);
                    check_read("instr", instr, {lotr_pkg::I_MEM_REGION, addr[23:0]},
                               mask[3:0], exp);
                end
            end
            32'h4: begin
                @(posedge qclk);
                d_addr  <= addr;
                d_rd_en <= 1'b1;
                @(posedge qclk);
                drive_idle();
                @(negedge qclk);
                check_read("d_rd_data", d_rd_data, {lotr_pkg::D_MEM_REGION, addr[23:0]},
                           mask[3:0], exp);
            end
            // Core store with byte enables
            32'h5: begin
                @(posedge qclk);
                d_addr    <= addr;
                d_wr_en   <= 1'b1;
                d_byte_en <= mask[3:0];
                d_wr_data <= data;
                @(posedge qclk);
                drive_idle();
                model_write({lotr_pkg::D_MEM_REGION, addr[23:0]}, data, mask[3:0]);
            end
            // Unmapped region where mask bit 0 picks a write
            32'h6: begin
                if (mask[0]) begin
                    miss_op = lotr_pkg::WR;
                end else begin
                    miss_op = lotr_pkg::RD;
                end
                fabric_cycle(miss_op, addr, data);
                check_value("f2c_rsp_valid", {31'h0, f2c_rsp_valid}, 32'h0);
                @(negedge qclk);
                check_value("f2c_rsp_valid", {31'h0, f2c_rsp_valid}, 32'h0);
            end
            // Fabric write and core read of one word return the old word
            32'h7: begin
                @(posedge qclk);
                drive_fabric(lotr_pkg::WR, addr, data);
                pc       <= addr;
                fetch_en <= is_imem(addr);
                d_addr   <= addr;
                d_rd_en  <= !is_imem(addr);
                @(posedge qclk);
                drive_idle();
                @(negedge qclk);
                if (is_imem(addr)) begin
                    check_read("instr", instr, addr, mask[3:0], exp);
                end else begin
                    check_read("d_rd_data", d_rd_data, addr, mask[3:0], exp);
                end
                model_write(addr, data, 4'hf);
            end
            default: begin
                errors++;
                $display("pattern %0d holds an unknown operation code %0h", idx, op);
            end
        endcase
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================
    initial begin
        int i;
        int run;
        // Read request held through reset
        drive_idle();
        drive_fabric(lotr_pkg::RD, 32'h0100_0000, 32'h0);
        lfsr_state = LFSR_SEED;
        checks     = 0;
        errors     = 0;
        for (int k = 0; k < 5*MAX_PATTERNS; k++) begin
            patterns[k] = 32'h0;
        end
        $readmemh("verif/mem_patterns.txt", patterns);
        n_patterns = 0;
        while (n_patterns < MAX_PATTERNS && pattern_field(n_patterns, 0) != 32'h0) begin
            n_patterns++;
        end
        cycle_limit = n_patterns * 4 + TIMEOUT_MARGIN;
        if (n_patterns == 0) begin
            errors++;
            $display("no patterns were read from verif/mem_patterns.txt");
        end

        // Valid stays low in reset and in the first cycle after
        for (int r = 0; r < RESET_CYCLES; r++) begin
            @(posedge qclk);
            if (r == RESET_CYCLES - 1) begin
                drive_idle();
            end
            @(negedge qclk);
            check_value("f2c_rsp_valid", {31'h0, f2c_rsp_valid}, 32'h0);
        end

        i = 0;
        while (i < n_patterns) begin
            if (pattern_field(i, 0) == 32'h8) begin
                run = 0;
                while (i + run < n_patterns && pattern_field(i + run, 0) == 32'h8) begin
                    run++;
                end
                fabric_burst(i, run);
                i = i + run;
            end else begin
                run_pattern(i);
                i++;
            end
        end

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Cycle budget from the pattern count
    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge qclk);
            cycle_count++;
        end
        $display("timeout, run did not finish within %0d cycles", cycle_limit);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic qclk,
    output logic rst_n
);

    // Free-running clock, first rising edge half a period in
    initial begin
        qclk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) qclk = ~qclk;
        end
    end

    // Reset low for the first cycles, released on a rising edge
    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge qclk);
        rst_n <= 1'b1;
    end

endmodule

//--- verilog/d_mem_wrap.sv
`timescale 1ns/1ps

module d_mem_wrap #(
    parameter int D_MEM_AW = 9
) (
    input  logic               qclk,
    input  logic               rst_n,

    // ==========================================================
    // Core load and store port
    // ==========================================================
    input  logic [31:0]        d_addr,
    input  logic               d_rd_en,
    input  logic               d_wr_en,
    input  logic [3:0]         d_byte_en,
    input  logic [31:0]        d_wr_data,
    output logic [31:0]        d_rd_data,

    // ==========================================================
    // Fabric request and response
    // ==========================================================
    input  logic               f2c_req_valid,
    input  lotr_pkg::t_opcode  f2c_req_opcode,
    input  logic [31:0]        f2c_req_address,
    input  logic [31:0]        f2c_req_data,
    output logic               f2c_rsp_dmem_valid,
    output logic [31:0]        f2c_dmem_rsp_data
);

    logic                f2c_dmem_hit;
    logic                f2c_rd_en;
    logic                f2c_wr_en;
    logic [D_MEM_AW-1:0] core_word_addr;
    logic [D_MEM_AW-1:0] f2c_word_addr;
    logic [3:0]          core_byte_wr;
    logic [3:0]          f2c_byte_wr;

    // Region decode against the data region
    assign f2c_dmem_hit = (f2c_req_address[lotr_pkg::MSB_REGION:lotr_pkg::LSB_REGION]
                           == lotr_pkg::D_MEM_REGION);

    // Fabric strobes gated by the hit
    assign f2c_rd_en = f2c_req_valid && (f2c_req_opcode == lotr_pkg::RD) && f2c_dmem_hit;
    assign f2c_wr_en = f2c_req_valid && (f2c_req_opcode == lotr_pkg::WR) && f2c_dmem_hit;

    // Word index from byte addresses
    assign core_word_addr = d_addr[D_MEM_AW+1:2];
    assign f2c_word_addr  = f2c_req_address[D_MEM_AW+1:2];

    // Store lanes only while a store is issued
    assign core_byte_wr = d_byte_en & {4{d_wr_en}};

    // Fabric always writes the whole word
    assign f2c_byte_wr = {4{f2c_wr_en}};

    // One-cycle response pulse per read hit
    // Writes and misses leave it low
    always_ff @(posedge qclk) begin
        if (!rst_n) begin
            f2c_rsp_dmem_valid <= 1'b0;
        end else begin
            f2c_rsp_dmem_valid <= f2c_rd_en;
        end
    end

    // Port a for core loads and stores, port b for the fabric
    dual_port_ram #(
        .AW (D_MEM_AW)
    ) d_mem_ram (
        .qclk      (qclk),
        // Core side
        .address_a (core_word_addr),
        .data_a    (d_wr_data),
        .rden_a    (d_rd_en),
        .byte_en_a (core_byte_wr),
        .q_a       (d_rd_data),
        // Fabric side
        .address_b (f2c_word_addr),
        .data_b    (f2c_req_data),
        .rden_b    (f2c_rd_en),
        .byte_en_b (f2c_byte_wr),
        .q_b       (f2c_dmem_rsp_data)
    );

endmodule

//--- verilog/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram #(
    parameter int AW = 9
) (
    input  logic          qclk,

    // ==========================================================
    // Port a
    // ==========================================================
    input  logic [AW-1:0] address_a,
    input  logic [31:0]   data_a,
    input  logic          rden_a,
    input  logic [3:0]    byte_en_a,
    output logic [31:0]   q_a,

    // ==========================================================
    // Port b
    // ==========================================================
    input  logic [AW-1:0] address_b,
    input  logic [31:0]   data_b,
    input  logic          rden_b,
    input  logic [3:0]    byte_en_b,
    output logic [31:0]   q_b
);

    // Word storage, 2**AW words of 32 bits
    logic [31:0] mem [0:(2**AW)-1];

    // Any byte lane active means a write on that port
    logic wren_a;
    logic wren_b;

    assign wren_a = |byte_en_a;
    assign wren_b = |byte_en_b;

    // Reads sample the array before this edge's writes land
    // so a same-word read and write return the old word
    always_ff @(posedge qclk) begin
        // Read port a, hold when not enabled
        if (rden_a) begin
            q_a <= mem[address_a];
        end

        // Read port b, hold when not enabled
        if (rden_b) begin
            q_b <= mem[address_b];
        end

        // Byte writes on port a
        if (wren_a) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en_a[i]) begin
                    mem[address_a][8*i +: 8] <= data_a[8*i +: 8];
                end
            end
        end

        // Byte writes on port b
        // Same word on both ports in one cycle is left undefined
        if (wren_b) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en_b[i]) begin
                    mem[address_b][8*i +: 8] <= data_b[8*i +: 8];
                end
            end
        end
    end

endmodule

//--- verilog/i_mem_wrap.sv
`timescale 1ns/1ps

module i_mem_wrap #(
    parameter int I_MEM_AW = 9
) (
    input  logic               qclk,
    input  logic               rst_n,

    // ==========================================================
    // Core fetch port
    // ==========================================================
    input  logic [31:0]        pc,
    input  logic               fetch_en,
    output logic [31:0]        instr,

    // ==========================================================
    // Fabric request and response
    // ==========================================================
    input  logic               f2c_req_valid,
    input  lotr_pkg::t_opcode  f2c_req_opcode,
    input  logic [31:0]        f2c_req_address,
    input  logic [31:0]        f2c_req_data,
    output logic               f2c_rsp_imem_valid,
    output logic [31:0]        f2c_imem_rsp_data
);

    logic                f2c_imem_hit;
    logic                f2c_rd_en;
    logic                f2c_wr_en;
    logic [I_MEM_AW-1:0] fetch_word_addr;
    logic [I_MEM_AW-1:0] f2c_word_addr;

    // Region decode on the upper address byte
    assign f2c_imem_hit = (f2c_req_address[lotr_pkg::MSB_REGION:lotr_pkg::LSB_REGION]
                           == lotr_pkg::I_MEM_REGION);

    // Read and write strobes for this memory only
    assign f2c_rd_en = f2c_req_valid && (f2c_req_opcode == lotr_pkg::RD) && f2c_imem_hit;
    assign f2c_wr_en = f2c_req_valid && (f2c_req_opcode == lotr_pkg::WR) && f2c_imem_hit;

    // Byte addresses to word index, low two bits dropped
    assign fetch_word_addr = pc[I_MEM_AW+1:2];
    assign f2c_word_addr   = f2c_req_address[I_MEM_AW+1:2];

    // Response valid follows a read hit by one cycle
    always_ff @(posedge qclk) begin
        if (!rst_n) begin
            f2c_rsp_imem_valid <= 1'b0;
        end else begin
            f2c_rsp_imem_valid <= f2c_rd_en;
        end
    end

    // Port a for the core (read only), port b for the fabric
    dual_port_ram #(
        .AW (I_MEM_AW)
    ) i_mem_ram (
        .qclk      (qclk),
        // Core fetch, never writes
        .address_a (fetch_word_addr),
        .data_a    (32'h0),
        .rden_a    (fetch_en),
        .byte_en_a (4'b0000),
        .q_a       (instr),
        // Fabric, full-word writes
        .address_b (f2c_word_addr),
        .data_b    (f2c_req_data),
        .rden_b    (f2c_rd_en),
        .byte_en_b ({4{f2c_wr_en}}),
        .q_b       (f2c_imem_rsp_data)
    );

endmodule

//--- verilog/lotr_pkg.sv
package lotr_pkg;

    // ==========================================================
    // Fabric request opcode
    // ==========================================================

    // Single bit on the ring request
    typedef enum logic [0:0] {
        RD = 1'b0,
        WR = 1'b1
    } t_opcode;

    // ==========================================================
    // Fabric address map
    // ==========================================================

    // Region field in the upper byte of a fabric address
    localparam int MSB_REGION = 31;
    localparam int LSB_REGION = 24;

    // Region width follows the field positions
    localparam int REGION_W = MSB_REGION - LSB_REGION + 1;

    // Instruction memory region
    localparam logic [REGION_W-1:0] I_MEM_REGION = 8'h01;

    // Data memory region
    localparam logic [REGION_W-1:0] D_MEM_REGION = 8'h02;

    // Any other region code is dropped by both wrappers
    // Lower address bits carry a byte address inside the region

endpackage

//--- verilog/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem #(
    parameter int I_MEM_AW = 9,
    parameter int D_MEM_AW = 9
) (
    input  logic               qclk,
    input  logic               rst_n,

    // ==========================================================
    // Core ports
    // ==========================================================
    // Instruction fetch
    input  logic [31:0]        pc,
    input  logic               fetch_en,
    output logic [31:0]        instr,
    // Loads and stores
    input  logic [31:0]        d_addr,
    input  logic               d_rd_en,
    input  logic               d_wr_en,
    input  logic [3:0]         d_byte_en,
    input  logic [31:0]        d_wr_data,
    output logic [31:0]        d_rd_data,

    // ==========================================================
    // Fabric ports
    // ==========================================================
    input  logic               f2c_req_valid,
    input  lotr_pkg::t_opcode  f2c_req_opcode,
    input  logic [31:0]        f2c_req_address,
    input  logic [31:0]        f2c_req_data,
    output logic               f2c_rsp_valid,
    output logic [31:0]        f2c_rsp_data
);

    // Per-memory responses
    logic        rsp_imem_valid;
    logic [31:0] rsp_imem_data;
    logic        rsp_dmem_valid;
    logic [31:0] rsp_dmem_data;

    // Instruction memory, request fanned out unchanged
    i_mem_wrap #(
        .I_MEM_AW (I_MEM_AW)
    ) i_mem (
        .qclk               (qclk),
        .rst_n              (rst_n),
        .pc                 (pc),
        .fetch_en           (fetch_en),
        .instr              (instr),
        .f2c_req_valid      (f2c_req_valid),
        .f2c_req_opcode     (f2c_req_opcode),
        .f2c_req_address    (f2c_req_address),
        .f2c_req_data       (f2c_req_data),
        .f2c_rsp_imem_valid (rsp_imem_valid),
        .f2c_imem_rsp_data  (rsp_imem_data)
    );

    // Data memory, same request
    d_mem_wrap #(
        .D_MEM_AW (D_MEM_AW)
    ) d_mem (
        .qclk               (qclk),
        .rst_n              (rst_n),
        .d_addr             (d_addr),
        .d_rd_en            (d_rd_en),
        .d_wr_en            (d_wr_en),
        .d_byte_en          (d_byte_en),
        .d_wr_data          (d_wr_data),
        .d_rd_data          (d_rd_data),
        .f2c_req_valid      (f2c_req_valid),
        .f2c_req_opcode     (f2c_req_opcode),
        .f2c_req_address    (f2c_req_address),
        .f2c_req_data       (f2c_req_data),
        .f2c_rsp_dmem_valid (rsp_dmem_valid),
        .f2c_dmem_rsp_data  (rsp_dmem_data)
    );

    // Response merge, regions are disjoint so one valid at most
    assign f2c_rsp_valid = rsp_imem_valid | rsp_dmem_valid;

    // Data from whichever memory answered
    always_comb begin
        if (rsp_imem_valid) begin
            f2c_rsp_data = rsp_imem_data;
        end else if (rsp_dmem_valid) begin
            f2c_rsp_data = rsp_dmem_data;
        end else begin
            f2c_rsp_data = 32'h0;
        end
    end

endmodule

//--- vlog.f
verilog/lotr_pkg.sv
verilog/dual_port_ram.sv
verilog/i_mem_wrap.sv
verilog/d_mem_wrap.sv
verilog/mem_subsystem.sv
verif/tb_clock_gen.sv
verif/mem_subsystem_props.sv
verif/mem_subsystem_tb.sv
